// ==== src/wword_pkg.sv ====
/* wide-word ring buffer definitions
   lane count, count and rotation types, pipeline latencies */
`default_nettype none

package wword_pkg;

	// words on the wide bus, fixed by the two-stage barrel shift
	localparam int LANES = 4;

	// word count carried by a strobe, zero to LANES
	typedef logic [2:0] lane_cnt_t;

	// lane rotation, the low bits of a word address
	typedef logic [1:0] rot_t;

	// one write enable per lane
	typedef logic [LANES-1:0] lane_mask_t;

	// accepted write strobe until its words can be read
	localparam int WR_LAT = 4;

	// sampling edge of an accepted read until rd_data and rd_valid
	localparam int RD_LAT = 6;

endpackage

`default_nettype wire

// ==== src/bank_ram.sv ====
/* single storage bank of the wide-word RAM
   simple dual port, read index and read data both registered */
`timescale 1ns/100ps
`default_nettype none

module bank_ram #(
	parameter int WORD_WIDTH = 64,
	parameter int ADDR_WIDTH = 11
) (
	input  wire                    clk,
	input  wire                    we,
	input  wire [ADDR_WIDTH-3:0]   wr_idx,
	input  wire [WORD_WIDTH-1:0]   din,
	input  wire [ADDR_WIDTH-3:0]   rd_idx,
	output logic [WORD_WIDTH-1:0]  q
);

	// each bank holds one word of every four
	localparam int DEPTH = 2 ** (ADDR_WIDTH - 2);

	logic [WORD_WIDTH-1:0] mem [DEPTH];
	logic [ADDR_WIDTH-3:0] rd_idx_q;

	// write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_idx] <= din;
		end
	end

	// read port, two cycles from rd_idx to q
	// a same-edge write to the read row returns old data
	always_ff @(posedge clk) begin
		rd_idx_q <= rd_idx;
		q <= mem[rd_idx_q];
	end

endmodule

`default_nettype wire

// ==== src/wide_word_ram.sv ====
/* four-bank RAM addressed by words
   barrel shift on write and read so any word can start a four-word access */
`timescale 1ns/100ps
`default_nettype none

module wide_word_ram #(
	parameter int WORD_WIDTH = 64,
	parameter int ADDR_WIDTH = 11
) (
	input  wire                                     clk,
	input  wire                                     arst,
	input  wire [wword_pkg::LANES*WORD_WIDTH-1:0]   din,
	input  wire [ADDR_WIDTH-1:0]                    wr_addr,
	input  wire                                     we,
	input  wire wword_pkg::lane_mask_t              wr_mask,
	input  wire [ADDR_WIDTH-1:0]                    rd_addr,
	output logic [wword_pkg::LANES*WORD_WIDTH-1:0]  dout
);

	import wword_pkg::*;

	localparam int ROW_W = ADDR_WIDTH - 2;
	localparam int BUS_W = LANES * WORD_WIDTH;
	// rotation delay across bank index and the two bank registers
	localparam int ROT_DLY = 3;

	typedef logic [ROW_W-1:0] row_t;
	typedef logic [BUS_W-1:0] bus_t;

	// bank b holds the words whose address is b modulo four
	// banks below the start lane belong to the next row
	function automatic lane_mask_t wrap_banks(input rot_t rot);
		lane_mask_t m;
		case (rot)
			2'd0: m = 4'h0;
			2'd1: m = 4'h1;
			2'd2: m = 4'h3;
			default: m = 4'h7;
		endcase
		return m;
	endfunction

	// swap the two halves of the bus
	function automatic bus_t bus_rot2(input bus_t b);
		return {b[2*WORD_WIDTH-1:0], b[BUS_W-1:2*WORD_WIDTH]};
	endfunction

	// lane i moves up to lane i+1
	function automatic bus_t bus_up1(input bus_t b);
		return {b[BUS_W-WORD_WIDTH-1:0], b[BUS_W-1:BUS_W-WORD_WIDTH]};
	endfunction

	// lane i+1 moves down to lane i
	function automatic bus_t bus_down1(input bus_t b);
		return {b[WORD_WIDTH-1:0], b[BUS_W-1:WORD_WIDTH]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// write path
	//////////////////////////////////////////////////////////////////////

	logic       wr_we_s1;
	bus_t       wr_din_s1;
	lane_mask_t wr_mask_s1;
	rot_t       wr_rot_s1;
	row_t       wr_row_s1;

	logic       wr_we_s2;
	bus_t       wr_din_s2;
	lane_mask_t wr_mask_s2;
	logic       wr_rot0_s2;
	lane_mask_t wr_wrap_s2;
	row_t       wr_row_s2;
	row_t       wr_row_next_s2;

	bus_t       wr_din_s3;
	lane_mask_t wr_bank_we_s3;
	row_t       wr_idx_s3 [LANES];

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			wr_we_s1 <= 1'b0;
			wr_we_s2 <= 1'b0;
			wr_bank_we_s3 <= '0;
		end else begin
			wr_we_s1 <= we;
			wr_we_s2 <= wr_we_s1;
			// finish the mask rotation and gate it with the strobe
			if (wr_rot0_s2) begin
				wr_bank_we_s3 <= {LANES{wr_we_s2}} & {wr_mask_s2[2:0], wr_mask_s2[3]};
			end else begin
				wr_bank_we_s3 <= {LANES{wr_we_s2}} & wr_mask_s2;
			end
		end
	end

	// input register, then rotate by two, then rotate by one
	always_ff @(posedge clk) begin
		wr_din_s1 <= din;
		wr_mask_s1 <= wr_mask;
		wr_rot_s1 <= wr_addr[1:0];
		wr_row_s1 <= wr_addr[ADDR_WIDTH-1:2];

		wr_din_s2 <= wr_rot_s1[1] ? bus_rot2(wr_din_s1) : wr_din_s1;
		wr_mask_s2 <= wr_rot_s1[1] ? {wr_mask_s1[1:0], wr_mask_s1[3:2]} : wr_mask_s1;
		wr_rot0_s2 <= wr_rot_s1[0];
		wr_wrap_s2 <= wrap_banks(wr_rot_s1);
		wr_row_s2 <= wr_row_s1;
		wr_row_next_s2 <= wr_row_s1 + 1'b1;

		wr_din_s3 <= wr_rot0_s2 ? bus_up1(wr_din_s2) : wr_din_s2;
	end

	//////////////////////////////////////////////////////////////////////
	// read addressing
	//////////////////////////////////////////////////////////////////////

	rot_t       rd_rot_s1;
	lane_mask_t rd_wrap_s1;
	row_t       rd_row_s1;
	row_t       rd_row_next_s1;
	row_t       rd_idx_s2 [LANES];
	rot_t       rd_rot_dly [ROT_DLY];

	always_ff @(posedge clk) begin
		rd_rot_s1 <= rd_addr[1:0];
		rd_wrap_s1 <= wrap_banks(rd_addr[1:0]);
		rd_row_s1 <= rd_addr[ADDR_WIDTH-1:2];
		rd_row_next_s1 <= rd_addr[ADDR_WIDTH-1:2] + 1'b1;

		// rotation follows the data through the banks
		rd_rot_dly[0] <= rd_rot_s1;
		for (int k = 1; k < ROT_DLY; k++) begin
			rd_rot_dly[k] <= rd_rot_dly[k-1];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// banks
	//////////////////////////////////////////////////////////////////////

	bus_t bank_q;

	for (genvar b = 0; b < LANES; b++) begin : g_bank
		always_ff @(posedge clk) begin
			wr_idx_s3[b] <= wr_wrap_s2[b] ? wr_row_next_s2 : wr_row_s2;
			rd_idx_s2[b] <= rd_wrap_s1[b] ? rd_row_next_s1 : rd_row_s1;
		end

		bank_ram #(
			.WORD_WIDTH(WORD_WIDTH),
			.ADDR_WIDTH(ADDR_WIDTH)
		) u_bank (
			.clk    (clk),
			.we     (wr_bank_we_s3[b]),
			.wr_idx (wr_idx_s3[b]),
			.din    (wr_din_s3[b*WORD_WIDTH +: WORD_WIDTH]),
			.rd_idx (rd_idx_s2[b]),
			.q      (bank_q[b*WORD_WIDTH +: WORD_WIDTH])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// read data rotate back, addressed word into lane 0
	//////////////////////////////////////////////////////////////////////

	bus_t rd_data_s5;
	logic rd_rot0_s5;

	always_ff @(posedge clk) begin
		rd_data_s5 <= rd_rot_dly[ROT_DLY-1][1] ? bus_rot2(bank_q) : bank_q;
		rd_rot0_s5 <= rd_rot_dly[ROT_DLY-1][0];
		dout <= rd_rot0_s5 ? bus_down1(rd_data_s5) : rd_data_s5;
	end

endmodule

`default_nettype wire

// ==== src/ring_ptr_ctrl.sv ====
/* ring pointer control for the wide-word RAM
   pointers, fill and credit counts, overflow and underflow checks */
`timescale 1ns/100ps
`default_nettype none

module ring_ptr_ctrl #(
	parameter int ADDR_WIDTH = 11
) (
	input  wire                        clk,
	input  wire                        arst,
	input  wire                        wr_strobe,
	input  wire wword_pkg::lane_cnt_t  wr_words,
	input  wire                        rd_strobe,
	input  wire wword_pkg::lane_cnt_t  rd_words,
	output logic [ADDR_WIDTH:0]        used_words,
	output logic                       overflow,
	output logic                       underflow,
	output logic                       rd_valid,
	output logic                       ram_we,
	output logic [ADDR_WIDTH-1:0]      ram_wr_addr,
	output wword_pkg::lane_mask_t      ram_wr_mask,
	output logic [ADDR_WIDTH-1:0]      ram_rd_addr
);

	import wword_pkg::*;

	typedef logic [ADDR_WIDTH:0] cnt_t;

	localparam cnt_t CAPACITY = cnt_t'(2 ** ADDR_WIDTH);

	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;
	// words written or in the write pipeline and not yet read
	cnt_t                  reserved;
	cnt_t                  free_words;
	cnt_t                  wr_cnt;
	cnt_t                  rd_cnt;
	cnt_t                  wr_acc_cnt;
	cnt_t                  rd_acc_cnt;
	logic                  wr_ok;
	logic                  rd_ok;
	// used_words is the last stage of the credit delay
	lane_cnt_t             credit [WR_LAT-1];
	logic [RD_LAT-1:0]     rd_pipe;

	assign free_words = CAPACITY - reserved;
	assign wr_cnt = cnt_t'(wr_words);
	assign rd_cnt = cnt_t'(rd_words);

	// both strobes see the counts as they stood before this cycle
	// counts above LANES cannot be carried by the bus
	assign wr_ok = wr_strobe && (wr_words <= LANES) && (free_words >= wr_cnt);
	assign rd_ok = rd_strobe && (rd_words <= LANES) && (used_words >= rd_cnt);

	assign wr_acc_cnt = wr_ok ? wr_cnt : '0;
	assign rd_acc_cnt = rd_ok ? rd_cnt : '0;

	// RAM controls in the cycle of acceptance
	assign ram_we = wr_ok;
	assign ram_wr_addr = wr_ptr;
	assign ram_rd_addr = rd_ptr;

	always_comb begin
		ram_wr_mask = '0;
		for (int i = 0; i < LANES; i++) begin
			ram_wr_mask[i] = lane_cnt_t'(i) < wr_words;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// pointers and counts
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			reserved <= '0;
			used_words <= '0;
			overflow <= 1'b0;
			underflow <= 1'b0;
		end else begin
			// pointers wrap at the ring capacity
			wr_ptr <= wr_ptr + wr_acc_cnt[ADDR_WIDTH-1:0];
			rd_ptr <= rd_ptr + rd_acc_cnt[ADDR_WIDTH-1:0];
			reserved <= reserved + wr_acc_cnt - rd_acc_cnt;
			used_words <= used_words + cnt_t'(credit[WR_LAT-2]) - rd_acc_cnt;
			overflow <= wr_strobe && !wr_ok;
			underflow <= rd_strobe && !rd_ok;
		end
	end

	// written words become readable once they are in the banks
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			for (int k = 0; k < WR_LAT - 1; k++) begin
				credit[k] <= '0;
			end
			rd_pipe <= '0;
		end else begin
			credit[0] <= wr_acc_cnt[2:0];
			for (int k = 1; k < WR_LAT - 1; k++) begin
				credit[k] <= credit[k-1];
			end
			// one bit per read in flight
			rd_pipe <= {rd_pipe[RD_LAT-2:0], rd_ok};
		end
	end

	assign rd_valid = rd_pipe[RD_LAT-1];

endmodule

`default_nettype wire

// ==== src/word_ring_buffer.sv ====
/* word ring buffer top level
   pointer control steering a four-lane wide-word RAM */
`timescale 1ns/100ps
`default_nettype none

module word_ring_buffer #(
	parameter int WORD_WIDTH = 64,
	parameter int ADDR_WIDTH = 11
) (
	input  wire                                     clk,
	input  wire                                     arst,
	input  wire                                     wr_strobe,
	input  wire wword_pkg::lane_cnt_t               wr_words,
	input  wire [wword_pkg::LANES*WORD_WIDTH-1:0]   wr_data,
	input  wire                                     rd_strobe,
	input  wire wword_pkg::lane_cnt_t               rd_words,
	output logic [wword_pkg::LANES*WORD_WIDTH-1:0]  rd_data,
	output logic                                    rd_valid,
	output logic [ADDR_WIDTH:0]                     used_words,
	output logic                                    overflow,
	output logic                                    underflow
);

	import wword_pkg::*;

	logic                  ram_we;
	logic [ADDR_WIDTH-1:0] ram_wr_addr;
	logic [ADDR_WIDTH-1:0] ram_rd_addr;
	lane_mask_t            ram_wr_mask;

	ring_ptr_ctrl #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_ctrl (
		.clk         (clk),
		.arst        (arst),
		.wr_strobe   (wr_strobe),
		.wr_words    (wr_words),
		.rd_strobe   (rd_strobe),
		.rd_words    (rd_words),
		.used_words  (used_words),
		.overflow    (overflow),
		.underflow   (underflow),
		.rd_valid    (rd_valid),
		.ram_we      (ram_we),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_mask (ram_wr_mask),
		.ram_rd_addr (ram_rd_addr)
	);

	// write data goes straight to the RAM, read data straight out
	wide_word_ram #(
		.WORD_WIDTH(WORD_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_ram (
		.clk     (clk),
		.arst    (arst),
		.din     (wr_data),
		.wr_addr (ram_wr_addr),
		.we      (ram_we),
		.wr_mask (ram_wr_mask),
		.rd_addr (ram_rd_addr),
		.dout    (rd_data)
	);

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
/* testbench clock and reset
   100 ns clock, reset held for 10 cycles */
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
	output logic clk,
	output logic arst
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// release a little after a rising edge
	initial begin
		arst = 1'b1;
		repeat (10) @(posedge clk);
		#10 arst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== dv/word_ring_asserts.sv ====
/* concurrent checks on the ring buffer strobes and counters */
`timescale 1ns/100ps
`default_nettype none

module word_ring_asserts #(
	parameter int ADDR_WIDTH = 11
) (
	input wire                  clk,
	input wire                  arst,
	input wire                  rd_strobe,
	input wire                  rd_valid,
	input wire                  underflow,
	input wire [ADDR_WIDTH:0]   used_words
);

	import wword_pkg::*;

	// a rejected read never returns data
	a_udf_no_valid: assert property (@(posedge clk) disable iff (arst)
		underflow |-> ##(RD_LAT-1) !rd_valid)
		else $error("rejected read produced rd_valid");

	a_used_max: assert property (@(posedge clk) disable iff (arst)
		used_words <= (2 ** ADDR_WIDTH))
		else $error("used_words above capacity");

	// every rd_valid goes back to a read strobe
	a_valid_src: assert property (@(posedge clk) disable iff (arst)
		rd_valid |-> $past(rd_strobe, RD_LAT))
		else $error("rd_valid without read strobe");

endmodule

bind word_ring_buffer word_ring_asserts #(.ADDR_WIDTH(ADDR_WIDTH)) u_asserts (
	.clk        (clk),
	.arst       (arst),
	.rd_strobe  (rd_strobe),
	.rd_valid   (rd_valid),
	.underflow  (underflow),
	.used_words (used_words)
);

`default_nettype wire

// ==== dv/tb_word_ring_buffer.sv ====
/* testbench for the word ring buffer
   word-queue reference model, negedge compare, directed and random tests */
`timescale 1ns/100ps
`default_nettype none

module tb_word_ring_buffer;

	import wword_pkg::*;

	localparam int WW = 64;
	localparam int AW = 5;
	localparam int CAP = 2 ** AW;
	localparam int BUS_W = LANES * WW;

	logic clk;
	logic arst;
	logic wr_strobe;
	lane_cnt_t wr_words;
	logic [BUS_W-1:0] wr_data;
	logic rd_strobe;
	lane_cnt_t rd_words;
	logic [BUS_W-1:0] rd_data;
	logic rd_valid;
	logic [AW:0] used_words;
	logic overflow;
	logic underflow;

	integer seed = 36806;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int cyc = 0;
	bit timeout_hit = 0;

	// reference model state, as it stands before the next edge
	logic [WW-1:0] words_q[$];
	int m_used = 0;
	int m_reserved = 0;
	int cr[WR_LAT-1] = '{default: 0};
	logic exp_ovf = 1'b0;
	logic exp_udf = 1'b0;
	int due_q[$];
	int n_q[$];
	logic [BUS_W-1:0] data_q[$];

	clk_gen u_clk (.clk(clk), .arst(arst));

	word_ring_buffer #(.WORD_WIDTH(WW), .ADDR_WIDTH(AW)) dut (
		.clk(clk), .arst(arst),
		.wr_strobe(wr_strobe), .wr_words(wr_words), .wr_data(wr_data),
		.rd_strobe(rd_strobe), .rd_words(rd_words),
		.rd_data(rd_data), .rd_valid(rd_valid), .used_words(used_words),
		.overflow(overflow), .underflow(underflow)
	);

	initial begin
		wr_strobe = 1'b0;
		wr_words = '0;
		wr_data = '0;
		rd_strobe = 1'b0;
		rd_words = '0;
	end

	function automatic bit write_fits(input int n);
		return n <= LANES && (CAP - m_reserved) >= n;
	endfunction

	function automatic bit read_fits(input int n);
		return n <= LANES && m_used >= n;
	endfunction

	// oldest words of the ring, lane aligned
	function automatic logic [BUS_W-1:0] model_read_lanes(input int n);
		logic [BUS_W-1:0] b;
		b = '0;
		for (int i = 0; i < n; i++) begin
			b[i*WW +: WW] = words_q[i];
		end
		return b;
	endfunction

	task automatic check_val(input string name, input longint got, input longint exp);
		check_cnt++;
		if (got != exp) begin
			err_cnt++;
			$display("Fail t=%0t %s: got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare process, outputs are stable at the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin : compare
		int wn;
		int rn;
		bit w_ok;
		bit r_ok;
		bit exp_valid;
		if (!arst) begin
			check_val("overflow", overflow, exp_ovf);
			check_val("underflow", underflow, exp_udf);
			check_val("used_words", used_words, m_used);
			exp_valid = due_q.size() > 0 && due_q[0] == cyc;
			check_val("rd_valid", rd_valid, exp_valid);
			if (exp_valid) begin
				for (int i = 0; i < n_q[0]; i++) begin
					check_val($sformatf("rd_data[%0d]", i), rd_data[i*WW +: WW],
						data_q[0][i*WW +: WW]);
				end
				void'(due_q.pop_front());
				void'(n_q.pop_front());
				void'(data_q.pop_front());
			end

			// step the model by the edge that follows
			wn = int'(wr_words);
			rn = int'(rd_words);
			w_ok = wr_strobe && write_fits(wn);
			r_ok = rd_strobe && read_fits(rn);
			exp_ovf = wr_strobe && !w_ok;
			exp_udf = rd_strobe && !r_ok;
			if (r_ok) begin
				due_q.push_back(cyc + RD_LAT);
				n_q.push_back(rn);
				data_q.push_back(model_read_lanes(rn));
				repeat (rn) void'(words_q.pop_front());
			end
			if (w_ok) begin
				for (int i = 0; i < wn; i++) begin
					words_q.push_back(wr_data[i*WW +: WW]);
				end
			end
			m_used = m_used + cr[WR_LAT-2] - (r_ok ? rn : 0);
			for (int k = WR_LAT - 2; k > 0; k--) begin
				cr[k] = cr[k-1];
			end
			cr[0] = w_ok ? wn : 0;
			m_reserved = m_reserved + (w_ok ? wn : 0) - (r_ok ? rn : 0);
			cyc++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic drive(input bit ws, input int wn, input bit rs, input int rn);
		logic [BUS_W-1:0] d;
		for (int i = 0; i < BUS_W / 32; i++) begin
			d[i*32 +: 32] = $random(seed);
		end
		@(posedge clk);
		#10;
		wr_strobe = ws;
		wr_words = lane_cnt_t'(wn);
		wr_data = d;
		rd_strobe = rs;
		rd_words = lane_cnt_t'(rn);
	endtask

	task automatic idle(input int n);
		repeat (n) drive(0, 0, 0, 0);
	endtask

	// until reads are out and all credits landed
	task automatic wait_drained();
		int n;
		n = 0;
		idle(2);
		while ((due_q.size() > 0 || m_used != m_reserved) && n < 100) begin
			idle(1);
			n++;
		end
		if (n >= 100) begin
			timeout_hit = 1;
			$display("timeout: read pipeline or credits did not drain");
		end
	endtask

	task automatic empty_ring();
		int n;
		n = 0;
		wait_drained();
		while (m_used > 0 && n < 40) begin
			drive(0, 0, 1, (m_used > LANES) ? LANES : m_used);
			idle(1);
			n++;
		end
		if (m_used > 0) begin
			timeout_hit = 1;
			$display("timeout: ring did not empty");
		end
		wait_drained();
	endtask

	task automatic end_test(input string name, input int err_before);
		test_cnt++;
		$display("test %0d %s: %s", test_cnt, name, (err_cnt == err_before) ? "ok" : "errors");
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	initial begin : main
		int e;
		int n;
		int wn;
		int rn;
		n = 0;
		while (arst && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (arst) begin
			timeout_hit = 1;
			$display("timeout: reset never released");
		end

		if (!timeout_hit) begin
			e = err_cnt;
			@(negedge clk);
			check_val("rd_valid", rd_valid, 0);
			check_val("overflow", overflow, 0);
			check_val("underflow", underflow, 0);
			check_val("used_words", used_words, 0);
			end_test("reset", e);
		end

		if (!timeout_hit) begin
			e = err_cnt;
			for (int i = 0; i < 8; i++) begin
				drive(1, 1, 0, 0);
				idle(WR_LAT);
				drive(0, 0, 1, 1);
			end
			wait_drained();
			end_test("single words", e);
		end

		if (!timeout_hit) begin
			e = err_cnt;
			for (int i = 0; i < 60 && !timeout_hit; i++) begin
				drive(1, i % 5, 0, 0);
				wait_drained();
				rn = (i * 3 + 1) % 5;
				drive(0, 0, 1, (rn > m_used) ? m_used : rn);
			end
			empty_ring();
			end_test("alignment and wrap", e);
		end

		if (!timeout_hit) begin
			e = err_cnt;
			for (int i = 0; i < CAP / LANES; i++) begin
				drive(1, LANES, 0, 0);
			end
			drive(1, 1, 0, 0);
			wait_drained();
			// eight four-word writes fill the ring exactly
			check_val("used_words", used_words, CAP);
			empty_ring();
			end_test("full and overflow", e);
		end

		if (!timeout_hit) begin
			e = err_cnt;
			drive(0, 0, 1, 1);
			drive(1, 3, 0, 0);
			drive(0, 0, 1, 2);
			wait_drained();
			drive(0, 0, 1, 3);
			drive(0, 0, 1, 1);
			wait_drained();
			end_test("underflow", e);
		end

		if (!timeout_hit) begin
			e = err_cnt;
			for (int i = 0; i < 2000; i++) begin
				wn = ($random(seed) & 32'h7fffffff) % 5;
				rn = ($random(seed) & 32'h7fffffff) % 5;
				drive($random(seed) & 1, wn, $random(seed) & 1, rn);
			end
			wait_drained();
			end_test("random mix", e);
		end

		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0 && !timeout_hit) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/wword_pkg.sv
src/bank_ram.sv
src/wide_word_ram.sv
src/ring_ptr_ctrl.sv
src/word_ring_buffer.sv
dv/clk_gen.sv
dv/word_ring_asserts.sv
dv/tb_word_ring_buffer.sv

// ==== Makefile ====
# Verilator build and run for the word ring buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_word_ring_buffer
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
